/* project.f */
rtl/dma_pkg.sv
rtl/beat_fifo.sv
rtl/axi_master_write_channel.sv
rtl/dma_write_ctrl.sv
rtl/dma_write_top.sv
verif/tb_clk_gen.sv
verif/dma_write_sva.sv
verif/tb_dma_write.sv

/* run_sim.sh */
#!/bin/sh
# build and run the DMA write testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_dma_write \
    -f project.f \
    -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* verif/tb_dma_write.sv */
// testbench for the DMA write engine, random AXI slave memory and producer against a queue model
`timescale 1ns/1ps

module tb_dma_write;

    logic clk, rst_n, in_valid, in_full, cmd_start, busy, xfer_done, xfer_err;
    logic aw_valid, aw_ready, w_valid, w_last, w_ready, b_ready, b_valid;
    logic [dma_pkg::DATA_W-1:0] in_data, w_data;
    logic [dma_pkg::ADDR_W-1:0] cmd_addr, aw_addr;
    logic [dma_pkg::CNT_W-1:0]  cmd_words;
    logic [dma_pkg::LEN_W-1:0]  aw_len;
    logic [2:0] aw_size;
    logic [1:0] aw_burst, b_resp;

    int seed = 86885;
    int errors = 0;
    int faults = 0;
    int cycles = 0;
    int limit = 1000000;
    int done_cnt = 0;
    int pushed = 0;
    int idle = 0;
    int err_rate = 0;
    bit stall = 1'b0;
    bit b_pend = 1'b0;
    bit exp_err = 1'b0;
    int cnt [11];
    int total;
    logic [dma_pkg::LEN_W-1:0]  beat, cur_len;
    logic [dma_pkg::ADDR_W-1:0] cur_addr;
    logic [dma_pkg::DATA_W-1:0] mem [logic [dma_pkg::ADDR_W-1:0]];
    logic [dma_pkg::ADDR_W-1:0] exp_addr_q [$];
    logic [dma_pkg::LEN_W-1:0]  exp_len_q [$];
    logic [dma_pkg::DATA_W-1:0] exp_word_q [$];

    tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    dma_write_top u_dma_write_top (.*);

    task automatic check_addr(input string name, input logic [dma_pkg::ADDR_W-1:0] exp,
                              input logic [dma_pkg::ADDR_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_len(input string name, input logic [dma_pkg::LEN_W-1:0] exp,
                             input logic [dma_pkg::LEN_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [dma_pkg::DATA_W-1:0] exp,
                              input logic [dma_pkg::DATA_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_idle(input string name);
        check_flag({name, " aw_valid"}, 1'b0, aw_valid);
        check_flag({name, " w_valid"}, 1'b0, w_valid);
        check_flag({name, " b_ready"}, 1'b0, b_ready);
        check_flag({name, " busy"}, 1'b0, busy);
        check_flag({name, " xfer_done"}, 1'b0, xfer_done);
        check_flag({name, " xfer_err"}, 1'b0, xfer_err);
        check_flag({name, " in_full"}, 1'b0, in_full);
    endtask

    // slave handshakes, response raised only after the last W beat
    always @(negedge clk) begin
        aw_ready = ({$random(seed)} % 4) != 0;
        w_ready = !stall && (({$random(seed)} % 3) != 0);
        if (!b_pend) begin
            b_valid = 1'b0;
            b_resp = 2'b00;
        end else if (!b_valid && ({$random(seed)} % 2) == 0) begin
            b_valid = 1'b1;
            if (({$random(seed)} % 100) < err_rate) begin
                b_resp = 2'b10;
                exp_err = 1'b1;
                // later bursts of the transfer answer OKAY
                err_rate = 0;
            end
        end
    end

    // bus monitor and slave memory
    always @(posedge clk) begin
        if (rst_n) begin
            if (aw_valid && aw_ready) begin
                if (exp_addr_q.size() == 0) begin
                    faults++;
                    $display("AW burst issued when no burst was expected");
                end else begin
                    check_addr("aw_addr", exp_addr_q.pop_front(), aw_addr);
                    check_len("aw_len", exp_len_q.pop_front(), aw_len);
                end
                check_flag("aw_size/aw_burst", 1'b1, aw_size == 3'b010 && aw_burst == 2'b01);
                cur_addr = aw_addr;
                cur_len = aw_len;
                beat = '0;
            end
            if (w_valid && w_ready) begin
                if (exp_word_q.size() == 0) begin
                    faults++;
                    $display("W beat sent with no word left to send");
                end else begin
                    check_word("w_data", exp_word_q.pop_front(), w_data);
                end
                check_flag("w_last", beat == cur_len, w_last);
                mem[cur_addr + {22'd0, beat, 2'b00}] = w_data;
                beat = beat + 1'b1;
                if (w_last) begin
                    b_pend = 1'b1;
                end
            end
            if (b_valid && b_ready) begin
                b_pend = 1'b0;
            end
            if (xfer_done) begin
                done_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic run_xfer(input string name, input int n, input int idle_pct,
                            input int err_pct, input bit full_test);
        logic [dma_pkg::DATA_W-1:0] words [$];
        logic [dma_pkg::ADDR_W-1:0] base;
        logic [dma_pkg::ADDR_W-1:0] a;
        int rem;
        int k;
        int j;
        int start_done;
        base = {$random(seed)} & 32'h0000_FFFC;
        a = base;
        rem = n;
        // expected bursts from the split rule
        while (rem > 0) begin
            k = (rem > 8) ? 8 : rem;
            exp_addr_q.push_back(a);
            exp_len_q.push_back(8'(k - 1));
            a = a + 32'(4 * k);
            rem -= k;
        end
        for (j = 0; j < n; j++) begin
            words.push_back($random(seed));
            exp_word_q.push_back(words[j]);
        end
        idle = idle_pct;
        err_rate = err_pct;
        exp_err = 1'b0;
        pushed = 0;
        stall = full_test;
        start_done = done_cnt;
        fork
            begin
                @(negedge clk);
                cmd_start = 1'b1;
                cmd_addr = base;
                cmd_words = 12'(n);
                @(negedge clk);
                cmd_start = 1'b0;
                check_flag({name, " xfer_err cleared"}, 1'b0, xfer_err);
                check_flag({name, " busy"}, 1'b1, busy);
            end
            begin
                j = 0;
                while (j < n) begin
                    @(negedge clk);
                    in_valid = 1'b0;
                    if (!in_full && ({$random(seed)} % 100) >= idle) begin
                        in_valid = 1'b1;
                        in_data = words[j];
                        j++;
                        pushed++;
                    end
                end
                @(negedge clk);
                in_valid = 1'b0;
            end
            begin
                if (full_test) begin
                    wait (pushed >= 16);
                    @(negedge clk);
                    check_flag({name, " in_full"}, 1'b1, in_full);
                    stall = 1'b0;
                end
            end
        join
        while (done_cnt == start_done) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        if (done_cnt != start_done + 1) begin
            faults++;
            $display("%s: xfer_done pulsed %0d times", name, done_cnt - start_done);
        end
        check_flag({name, " xfer_err"}, exp_err, xfer_err);
        for (j = 0; j < n; j++) begin
            check_word({name, " memory"}, words[j], mem[base + 32'(4 * j)]);
        end
        if (exp_addr_q.size() != 0 || exp_word_q.size() != 0) begin
            faults++;
            $display("%s: expected bursts or words were never sent", name);
        end
    endtask

    initial begin
        in_valid = 1'b0;
        in_data = '0;
        cmd_start = 1'b0;
        cmd_addr = '0;
        cmd_words = '0;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        b_valid = 1'b0;
        b_resp = 2'b00;
        cnt[0] = 5;
        for (int t = 1; t < 8; t++) begin
            cnt[t] = 1 + int'({$random(seed)} % 40);
        end
        cnt[8] = 20;
        cnt[9] = 12;
        cnt[10] = 24;
        total = 0;
        foreach (cnt[t]) begin
            total += cnt[t];
        end
        limit = 200 * total + 1000;
        // first reset edge, outputs are unknown before it
        @(posedge clk);
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            if (rst_n !== 1'b1) begin
                check_idle("reset");
            end
        end
        check_idle("after reset");
        run_xfer("single", cnt[0], 0, 0, 1'b0);
        for (int t = 1; t < 5; t++) begin
            run_xfer("split", cnt[t], 10, 0, 1'b0);
        end
        for (int t = 5; t < 8; t++) begin
            run_xfer("backpressure", cnt[t], 60, 0, 1'b0);
        end
        run_xfer("error", cnt[8], 0, 100, 1'b0);
        run_xfer("clear", cnt[9], 0, 0, 1'b0);
        run_xfer("fifo_full", cnt[10], 0, 0, 1'b1);
        repeat (5) @(negedge clk);
        $display("value mismatches: %0d, other failures: %0d", errors, faults);
        if (errors == 0 && faults == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* verif/dma_write_sva.sv */
// AXI write protocol and producer assertions, bound into the DMA write top level
`timescale 1ns/1ps

module dma_write_sva (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        in_valid,
    input logic                        in_full,
    input logic                        aw_valid,
    input logic                        aw_ready,
    input logic [dma_pkg::ADDR_W-1:0]  aw_addr,
    input logic [dma_pkg::LEN_W-1:0]   aw_len,
    input logic                        w_valid,
    input logic                        w_ready,
    input logic [dma_pkg::DATA_W-1:0]  w_data,
    input logic                        w_last,
    input logic                        b_ready
);

    logic [dma_pkg::LEN_W-1:0] beat_cnt;
    logic                      rst_seen = 1'b0;

    // W beats seen since the last AW transfer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            rst_seen <= 1'b1;
        end else if (aw_valid && aw_ready) begin
            beat_cnt <= '0;
        end else if (w_valid && w_ready) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr) && $stable(aw_len))
        else $error("aw channel changed before aw_ready");

    assert property (@(posedge clk) disable iff (!rst_n)
        w_valid && !w_ready |=> w_valid && $stable(w_data))
        else $error("w channel changed before w_ready");

    assert property (@(posedge clk) disable iff (!rst_n)
        w_valid |-> (w_last == (beat_cnt == aw_len)))
        else $error("w_last not on the final beat of the burst");

    assert property (@(posedge clk) disable iff (!rst_n) in_valid |-> !in_full)
        else $error("producer pushed while in_full");

    assert property (@(posedge clk) rst_seen && !rst_n |-> !aw_valid && !w_valid && !b_ready)
        else $error("AXI valid or ready high during reset");

endmodule

bind dma_write_top dma_write_sva u_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_full  (in_full),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .aw_addr  (aw_addr),
    .aw_len   (aw_len),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .w_data   (w_data),
    .w_last   (w_last),
    .b_ready  (b_ready)
);

/* verif/tb_clk_gen.sv */
// testbench clock and reset source, 10 ns clock with rst_n held low for 16 cycles
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* rtl/dma_write_top.sv */
// DMA write engine top, producer FIFO and command in, AXI write master out
`timescale 1ns/1ps

module dma_write_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  logic [dma_pkg::DATA_W-1:0]  in_data,
    output logic                        in_full,
    input  logic                        cmd_start,
    input  logic [dma_pkg::ADDR_W-1:0]  cmd_addr,
    input  logic [dma_pkg::CNT_W-1:0]   cmd_words,
    output logic                        busy,
    output logic                        xfer_done,
    output logic                        xfer_err,
    output logic [dma_pkg::ADDR_W-1:0]  aw_addr,
    output logic                        aw_valid,
    output logic [dma_pkg::LEN_W-1:0]   aw_len,
    output logic [2:0]                  aw_size,
    output logic [1:0]                  aw_burst,
    input  logic                        aw_ready,
    output logic                        w_valid,
    output logic [dma_pkg::DATA_W-1:0]  w_data,
    output logic                        w_last,
    input  logic                        w_ready,
    output logic                        b_ready,
    input  logic                        b_valid,
    input  logic [1:0]                  b_resp
);

    logic [dma_pkg::DATA_W-1:0] fifo_rdata;
    logic                       fifo_empty;
    logic                       fifo_pull;
    logic                       burst_start;
    logic [dma_pkg::ADDR_W-1:0] burst_addr;
    logic [dma_pkg::LEN_W-1:0]  burst_len;
    logic                       burst_done;
    logic                       burst_err;

    beat_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (in_valid),
        .push_data (in_data),
        .pop       (fifo_pull),
        .pop_data  (fifo_rdata),
        .empty     (fifo_empty),
        .full      (in_full)
    );

    dma_write_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_start   (cmd_start),
        .cmd_addr    (cmd_addr),
        .cmd_words   (cmd_words),
        .burst_done  (burst_done),
        .burst_err   (burst_err),
        .burst_start (burst_start),
        .burst_addr  (burst_addr),
        .burst_len   (burst_len),
        .busy        (busy),
        .xfer_done   (xfer_done),
        .xfer_err    (xfer_err)
    );

    axi_master_write_channel u_wch (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .start                  (burst_start),
        .target_write_addr      (burst_addr),
        .target_write_burst_len (burst_len),
        .fifo_rdata             (fifo_rdata),
        .fifo_empty             (fifo_empty),
        .fifo_pull              (fifo_pull),
        .done                   (burst_done),
        .resp_err               (burst_err),
        .aw_addr                (aw_addr),
        .aw_valid               (aw_valid),
        .aw_len                 (aw_len),
        .aw_size                (aw_size),
        .aw_burst               (aw_burst),
        .aw_ready               (aw_ready),
        .w_valid                (w_valid),
        .w_data                 (w_data),
        .w_last                 (w_last),
        .w_ready                (w_ready),
        .b_ready                (b_ready),
        .b_valid                (b_valid),
        .b_resp                 (b_resp)
    );

endmodule

/* rtl/dma_write_ctrl.sv */
// splits a DMA write command into bursts and tracks completion and error status
`timescale 1ns/1ps

module dma_write_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cmd_start,
    input  logic [dma_pkg::ADDR_W-1:0]  cmd_addr,
    input  logic [dma_pkg::CNT_W-1:0]   cmd_words,
    input  logic                        burst_done,
    input  logic                        burst_err,
    output logic                        burst_start,
    output logic [dma_pkg::ADDR_W-1:0]  burst_addr,
    output logic [dma_pkg::LEN_W-1:0]   burst_len,
    output logic                        busy,
    output logic                        xfer_done,
    output logic                        xfer_err
);

    logic [dma_pkg::CNT_W-1:0]  remaining;
    logic [dma_pkg::CNT_W-1:0]  cur_beats;
    logic [dma_pkg::CNT_W-1:0]  left_after;
    logic [dma_pkg::ADDR_W-1:0] next_addr;
    logic [dma_pkg::ADDR_W-1:0] step_bytes;
    logic                       accept;
    logic                       finish;

    assign accept = cmd_start && !busy;
    assign finish = busy && burst_done;

    // current burst is min(BURST_MAX, remaining)
    assign cur_beats = (remaining > dma_pkg::BURST_MAX) ? dma_pkg::BURST_MAX : remaining;
    assign left_after = remaining - cur_beats;
    assign step_bytes = {{(dma_pkg::ADDR_W - dma_pkg::CNT_W){1'b0}}, cur_beats}
                        * dma_pkg::BYTES_PER_BEAT;

    assign burst_addr = next_addr;
    assign burst_len = cur_beats[dma_pkg::LEN_W-1:0] - 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            burst_start <= 1'b0;
            xfer_done <= 1'b0;
            xfer_err <= 1'b0;
            remaining <= '0;
        end else begin
            burst_start <= 1'b0;
            xfer_done <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                burst_start <= 1'b1;
                xfer_err <= 1'b0;
                remaining <= cmd_words;
            end else if (finish) begin
                remaining <= left_after;
                // sticky until the next command
                if (burst_err) begin
                    xfer_err <= 1'b1;
                end
                if (left_after == '0) begin
                    busy <= 1'b0;
                    xfer_done <= 1'b1;
                end else begin
                    burst_start <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            next_addr <= cmd_addr;
        end else if (finish) begin
            next_addr <= next_addr + step_bytes;
        end
    end

endmodule

/* rtl/axi_master_write_channel.sv */
// AXI write master for one INCR burst at a time, W data taken from the beat FIFO
`timescale 1ns/1ps

module axi_master_write_channel (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [dma_pkg::ADDR_W-1:0]  target_write_addr,
    input  logic [dma_pkg::LEN_W-1:0]   target_write_burst_len,
    input  logic [dma_pkg::DATA_W-1:0]  fifo_rdata,
    input  logic                        fifo_empty,
    output logic                        fifo_pull,
    output logic                        done,
    output logic                        resp_err,
    output logic [dma_pkg::ADDR_W-1:0]  aw_addr,
    output logic                        aw_valid,
    output logic [dma_pkg::LEN_W-1:0]   aw_len,
    output logic [2:0]                  aw_size,
    output logic [1:0]                  aw_burst,
    input  logic                        aw_ready,
    output logic                        w_valid,
    output logic [dma_pkg::DATA_W-1:0]  w_data,
    output logic                        w_last,
    input  logic                        w_ready,
    output logic                        b_ready,
    input  logic                        b_valid,
    input  logic [1:0]                  b_resp
);

    logic [2:0]                 state;
    logic [2:0]                 n_state;
    logic [dma_pkg::ADDR_W-1:0] addr_q;
    logic [dma_pkg::LEN_W-1:0]  len_q;
    logic [dma_pkg::LEN_W-1:0]  snd_cnt;
    logic                       err_q;
    logic                       aw_fire;
    logic                       w_fire;
    logic                       b_fire;

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire = w_valid && w_ready;
    assign b_fire = b_valid && b_ready;

    // AW channel, fixed size and burst type
    assign aw_valid = (state == dma_pkg::WCH_ADDR);
    assign aw_addr = addr_q;
    assign aw_len = len_q;
    assign aw_size = dma_pkg::AXI_SIZE_4B;
    assign aw_burst = dma_pkg::AXI_BURST_INCR;

    // W beats straight off the FIFO head
    assign w_valid = (state == dma_pkg::WCH_DATA) && !fifo_empty;
    assign w_data = fifo_rdata;
    assign w_last = (state == dma_pkg::WCH_DATA) && (snd_cnt == len_q);
    assign fifo_pull = w_fire;

    assign b_ready = (state == dma_pkg::WCH_RESP);
    assign done = (state == dma_pkg::WCH_DONE);
    assign resp_err = done && err_q;

    always_comb begin
        n_state = state;
        case (state)
            dma_pkg::WCH_IDLE: begin
                if (start) begin
                    n_state = dma_pkg::WCH_ADDR;
                end
            end
            dma_pkg::WCH_ADDR: begin
                if (aw_fire) begin
                    n_state = dma_pkg::WCH_DATA;
                end
            end
            dma_pkg::WCH_DATA: begin
                if (w_fire && w_last) begin
                    n_state = dma_pkg::WCH_RESP;
                end
            end
            // any response code closes the burst
            dma_pkg::WCH_RESP: begin
                if (b_fire) begin
                    n_state = dma_pkg::WCH_DONE;
                end
            end
            default: n_state = dma_pkg::WCH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= dma_pkg::WCH_IDLE;
            snd_cnt <= '0;
            err_q <= 1'b0;
        end else begin
            state <= n_state;
            if (state == dma_pkg::WCH_IDLE) begin
                snd_cnt <= '0;
            end else if (w_fire) begin
                snd_cnt <= snd_cnt + 1'b1;
            end
            if (b_fire) begin
                err_q <= (b_resp != dma_pkg::AXI_RESP_OKAY);
            end
        end
    end

    // burst parameters captured on start
    always_ff @(posedge clk) begin
        if (state == dma_pkg::WCH_IDLE && start) begin
            addr_q <= target_write_addr;
            len_q <= target_write_burst_len;
        end
    end

endmodule

/* rtl/beat_fifo.sv */
// single-clock first-word-fall-through FIFO buffering producer words until W beats take them
`timescale 1ns/1ps

module beat_fifo (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        push,
    input  logic [dma_pkg::DATA_W-1:0]  push_data,
    input  logic                        pop,
    output logic [dma_pkg::DATA_W-1:0]  pop_data,
    output logic                        empty,
    output logic                        full
);

    logic [dma_pkg::DATA_W-1:0]  mem [0:dma_pkg::FIFO_DEPTH-1];
    logic [dma_pkg::FIFO_AW-1:0] wr_ptr;
    logic [dma_pkg::FIFO_AW-1:0] rd_ptr;
    logic [dma_pkg::FIFO_AW:0]   count;
    logic                        do_push;
    logic                        do_pop;

    // overflow and underflow requests are dropped
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    assign empty = (count == '0);
    assign full = (count == dma_pkg::FIFO_DEPTH);
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* rtl/dma_pkg.sv */
// shared widths, limits, AXI codes and write channel state codes for the DMA write path
package dma_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int LEN_W = 8;
    localparam int CNT_W = 12;

    // split rule and buffering
    localparam logic [CNT_W-1:0] BURST_MAX = CNT_W'(8);
    localparam int FIFO_AW = 4;
    localparam logic [FIFO_AW:0] FIFO_DEPTH = {1'b1, {FIFO_AW{1'b0}}};
    localparam logic [ADDR_W-1:0] BYTES_PER_BEAT = ADDR_W'(4);

    // AXI encodings
    localparam logic [2:0] AXI_SIZE_4B = 3'b010;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // write channel FSM
    localparam logic [2:0] WCH_IDLE = 3'd0;
    localparam logic [2:0] WCH_ADDR = 3'd1;
    localparam logic [2:0] WCH_DATA = 3'd2;
    localparam logic [2:0] WCH_RESP = 3'd3;
    localparam logic [2:0] WCH_DONE = 3'd4;

endpackage
